// ==== hw/diff_collector.sv ====
`timescale 1ns/1ps

module diff_collector import diff_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  sample_t              i_lane_y [NUM_LANES],
  input  logic [NUM_LANES-1:0] i_lane_ovf,
  input  logic                 i_lane_valid,
  input  logic                 i_lane_last,
  output sample_t              o_y [NUM_LANES],
  output logic                 o_valid,
  output logic                 o_last,
  output logic                 o_frame_ovf
);

  // Overflow seen earlier in the current frame
  logic ovf_sticky_q;
  logic beat_ovf;
  logic frame_end;

  assign beat_ovf  = i_lane_valid && (|i_lane_ovf);
  assign frame_end = i_lane_valid && i_lane_last;

  //////////////////////////////////////////////////////////////////////
  // Output beat
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_lane_valid) begin
      o_y <= i_lane_y;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_valid <= 1'b0;
      o_last  <= 1'b0;
    end else begin
      o_valid <= i_lane_valid;
      o_last  <= frame_end;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sticky frame overflow
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ovf_sticky_q <= 1'b0;
      o_frame_ovf  <= 1'b0;
    end else if (frame_end) begin
      // Report including the last beat itself, then start clean
      o_frame_ovf  <= ovf_sticky_q || beat_ovf;
      ovf_sticky_q <= 1'b0;
    end else begin
      o_frame_ovf <= 1'b0;
      if (beat_ovf) begin
        ovf_sticky_q <= 1'b1;
      end
    end
  end

  // Flag only qualified by the frame's last beat
  a_ovf_with_last: assert property (
    @(posedge clk) disable iff (!rst_n)
    o_frame_ovf |-> o_last
  );

endmodule

// ==== hw/diff_feeder.sv ====
`timescale 1ns/1ps

module diff_feeder import diff_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    i_valid,
  input  logic    i_last,
  input  logic    i_switch,
  input  sample_t i_data [NUM_LANES],
  output sample_t o_op_a [NUM_LANES],
  output sample_t o_op_b [NUM_LANES],
  output logic    o_op_strobe,
  output logic    o_op_last
);

  // Frame tracking
  frame_state_t state_q;
  logic         real_q;
  logic         tail_pend_q;
  sample_t      held_q [NUM_LANES];

  // Pairing stage, one beat waiting for its operands to be built
  logic         pair_pend_q;
  logic         pair_tail_q;
  logic         pair_real_q;
  sample_t      pair_beat_q [NUM_LANES];
  sample_t      pair_a [NUM_LANES];
  sample_t      pair_b [NUM_LANES];
  int           stride;

  // Successor arrived for the held beat
  logic         fwd_go;
  logic         pair_load;

  assign fwd_go    = i_valid && (state_q == FRM_HOLD);
  assign pair_load = fwd_go || tail_pend_q;

  //////////////////////////////////////////////////////////////////////
  // Frame state and mode latch
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= FRM_IDLE;
      real_q      <= 1'b1;
      tail_pend_q <= 1'b0;
    end else begin
      // A last beat has no successor, flush it on the next edge
      tail_pend_q <= i_valid && i_last;
      if (i_valid) begin
        // Mode only taken from the first beat of a frame
        if (state_q == FRM_IDLE) begin
          real_q <= i_switch;
        end
        state_q <= i_last ? FRM_IDLE : FRM_HOLD;
      end
    end
  end

  // Beat storage
  always_ff @(posedge clk) begin
    if (i_valid) begin
      held_q <= i_data;
    end
    if (pair_load) begin
      pair_beat_q <= held_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pairing stage
  //////////////////////////////////////////////////////////////////////

  // fwd_go only happens in FRM_HOLD, tail_pend_q only after a return to
  // FRM_IDLE, so the two loads never collide
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pair_pend_q <= 1'b0;
      pair_tail_q <= 1'b0;
      pair_real_q <= 1'b1;
    end else begin
      pair_pend_q <= pair_load;
      if (pair_load) begin
        pair_tail_q <= tail_pend_q;
        pair_real_q <= real_q;
      end
    end
  end

  assign stride = pair_real_q ? STRIDE_REAL : STRIDE_CPLX;

  // Lanes below NUM_LANES-stride pair inside the beat. The top lanes take
  // their successor from the next beat, which now sits in held_q, or for
  // the frame tail fall back to the backward difference
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      pair_a[i] = pair_beat_q[i];
      pair_b[i] = pair_beat_q[i];
      if (i + stride < NUM_LANES) begin
        pair_b[i] = pair_beat_q[i + stride];
      end else if (!pair_tail_q) begin
        pair_b[i] = held_q[i + stride - NUM_LANES];
      end else begin
        pair_a[i] = pair_beat_q[i - stride];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operand outputs
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (pair_pend_q) begin
      o_op_a <= pair_a;
      o_op_b <= pair_b;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_op_strobe <= 1'b0;
      o_op_last   <= 1'b0;
    end else begin
      o_op_strobe <= pair_pend_q;
      o_op_last   <= pair_pend_q && pair_tail_q;
    end
  end

  // Upstream must mark the last beat on a valid strobe only
  a_last_needs_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    i_last |-> i_valid
  );

endmodule

// ==== hw/diff_lane.sv ====
`timescale 1ns/1ps

module diff_lane import diff_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  sample_t i_op_a,
  input  sample_t i_op_b,
  input  logic    i_op_strobe,
  input  logic    i_op_last,
  output sample_t o_y,
  output logic    o_ovf,
  output logic    o_valid,
  output logic    o_last
);

  diff_t diff;

  // Both operands sign extended before the subtraction
  assign diff = diff_t'(i_op_b) - diff_t'(i_op_a);

  // Sign bit on top of the low 15 bits
  always_ff @(posedge clk) begin
    if (i_op_strobe) begin
      o_y <= {diff[DIFF_W-1], diff[SAMPLE_W-2:0]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_ovf   <= 1'b0;
      o_valid <= 1'b0;
      o_last  <= 1'b0;
    end else begin
      o_valid <= i_op_strobe;
      o_last  <= i_op_last;
      if (i_op_strobe) begin
        // Packing drops bit 15, lost when it disagrees with the sign
        o_ovf <= diff[DIFF_W-1] ^ diff[DIFF_W-2];
      end
    end
  end

  // The feeder must never raise last outside a strobe
  a_last_with_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    o_last |-> o_valid
  );

endmodule

// ==== hw/diff_pkg.sv ====
package diff_pkg;

  //////////////////////////////////////////////////////////////////////
  // Beat geometry
  //////////////////////////////////////////////////////////////////////

  // Samples carried by one input beat
  localparam int NUM_LANES = 8;

  // Input sample width and the full-precision difference
  localparam int SAMPLE_W = 16;
  localparam int DIFF_W   = SAMPLE_W + 1;

  // Successor distance in lanes, one per mode
  localparam int STRIDE_REAL = 1;
  localparam int STRIDE_CPLX = 2;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  // Input sample, also used for the packed 16-bit output
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Unpacked subtraction result, one guard bit above the sample
  typedef logic signed [DIFF_W-1:0] diff_t;

  // Feeder frame tracking
  typedef enum logic {
    FRM_IDLE,   // no beat waiting for a successor
    FRM_HOLD    // one beat held until the next one arrives
  } frame_state_t;

endpackage

// ==== hw/diff_top.sv ====
`timescale 1ns/1ps

module diff_top import diff_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    i_valid,
  input  logic    i_last,
  input  logic    i_switch,
  input  sample_t i_data [NUM_LANES],
  output sample_t o_y [NUM_LANES],
  output logic    o_valid,
  output logic    o_last,
  output logic    o_frame_ovf
);

  // Feeder to lanes
  sample_t              op_a [NUM_LANES];
  sample_t              op_b [NUM_LANES];
  logic                 op_strobe;
  logic                 op_last;

  // Lanes to collector
  sample_t              lane_y [NUM_LANES];
  logic [NUM_LANES-1:0] lane_ovf;
  logic [NUM_LANES-1:0] lane_valid;
  logic [NUM_LANES-1:0] lane_last;

  diff_feeder u_feeder (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_valid     (i_valid),
    .i_last      (i_last),
    .i_switch    (i_switch),
    .i_data      (i_data),
    .o_op_a      (op_a),
    .o_op_b      (op_b),
    .o_op_strobe (op_strobe),
    .o_op_last   (op_last)
  );

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    diff_lane u_lane (
      .clk         (clk),
      .rst_n       (rst_n),
      .i_op_a      (op_a[g]),
      .i_op_b      (op_b[g]),
      .i_op_strobe (op_strobe),
      .i_op_last   (op_last),
      .o_y         (lane_y[g]),
      .o_ovf       (lane_ovf[g]),
      .o_valid     (lane_valid[g]),
      .o_last      (lane_last[g])
    );
  end

  // Lane 0 speaks for the whole beat
  diff_collector u_collector (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_lane_y     (lane_y),
    .i_lane_ovf   (lane_ovf),
    .i_lane_valid (lane_valid[0]),
    .i_lane_last  (lane_last[0]),
    .o_y          (o_y),
    .o_valid      (o_valid),
    .o_last       (o_last),
    .o_frame_ovf  (o_frame_ovf)
  );

endmodule

// ==== test/tb_diff_cases.svh ====
`ifndef TB_DIFF_CASES_SVH
`define TB_DIFF_CASES_SVH

//////////////////////////////////////////////////////////////////////
// Frame table types
//////////////////////////////////////////////////////////////////////

// How the samples of a frame are filled
typedef enum logic [1:0] {
  FILL_RAND,     // full-range random samples
  FILL_RAMP,     // x[n] = n * param, wrapping in 16 bits
  FILL_EXTREME   // square wave of full scale, runs of param samples
} fill_kind_t;

// One frame: mode, length, fill and idle cycles after every beat
typedef struct packed {
  logic       real_mode;
  int         beats;
  fill_kind_t fill;
  int         param;
  int         gap;
} frame_case_t;

localparam sample_t FULL_POS = 16'sh7fff;
localparam sample_t FULL_NEG = 16'sh8000;

// Longest frame the model arrays can hold
localparam int MAX_BEATS   = 8;
localparam int MAX_SAMPLES = MAX_BEATS * NUM_LANES;

localparam int NUM_CASES = 25;

//////////////////////////////////////////////////////////////////////
// Frame table
//////////////////////////////////////////////////////////////////////

localparam frame_case_t CASES [NUM_CASES] = '{
  // Real mode, several beats, back to back
  '{real_mode: 1'b1, beats: 4, fill: FILL_RAND,    param: 0,    gap: 0},
  '{real_mode: 1'b1, beats: 6, fill: FILL_RAND,    param: 0,    gap: 0},
  '{real_mode: 1'b1, beats: 3, fill: FILL_RAMP,    param: 7,    gap: 0},
  '{real_mode: 1'b1, beats: 5, fill: FILL_RAMP,    param: -300, gap: 0},
  // Complex mode, stride 2 on re and im
  '{real_mode: 1'b0, beats: 4, fill: FILL_RAND,    param: 0,    gap: 0},
  '{real_mode: 1'b0, beats: 3, fill: FILL_RAMP,    param: 11,   gap: 0},
  '{real_mode: 1'b0, beats: 5, fill: FILL_RAND,    param: 0,    gap: 0},
  // Single-beat frames and short frames right after a last beat
  '{real_mode: 1'b1, beats: 1, fill: FILL_RAND,    param: 0,    gap: 0},
  '{real_mode: 1'b0, beats: 1, fill: FILL_RAND,    param: 0,    gap: 0},
  '{real_mode: 1'b1, beats: 1, fill: FILL_RAMP,    param: 3,    gap: 0},
  '{real_mode: 1'b0, beats: 2, fill: FILL_RAMP,    param: 1000, gap: 0},
  '{real_mode: 1'b1, beats: 2, fill: FILL_RAND,    param: 0,    gap: 0},
  // Full scale, some frames overflow and some do not
  '{real_mode: 1'b1, beats: 2, fill: FILL_EXTREME, param: 1,    gap: 0},
  '{real_mode: 1'b1, beats: 3, fill: FILL_EXTREME, param: 64,   gap: 0},
  '{real_mode: 1'b0, beats: 2, fill: FILL_EXTREME, param: 1,    gap: 0},
  '{real_mode: 1'b0, beats: 2, fill: FILL_EXTREME, param: 2,    gap: 0},
  '{real_mode: 1'b1, beats: 4, fill: FILL_EXTREME, param: 12,   gap: 0},
  '{real_mode: 1'b1, beats: 2, fill: FILL_RAMP,    param: 4096, gap: 0},
  '{real_mode: 1'b0, beats: 3, fill: FILL_RAMP,    param: 1,    gap: 0},
  // Idle cycles between beats
  '{real_mode: 1'b1, beats: 4, fill: FILL_RAND,    param: 0,    gap: 3},
  '{real_mode: 1'b0, beats: 3, fill: FILL_RAMP,    param: 5,    gap: 2},
  '{real_mode: 1'b1, beats: 1, fill: FILL_EXTREME, param: 1,    gap: 5},
  '{real_mode: 1'b0, beats: 5, fill: FILL_RAND,    param: 0,    gap: 1},
  '{real_mode: 1'b1, beats: 3, fill: FILL_EXTREME, param: 9,    gap: 4},
  '{real_mode: 1'b1, beats: 2, fill: FILL_RAND,    param: 0,    gap: 0}
};

`endif

// ==== test/tb_diff_top.sv ====
`timescale 1ns/1ps

module tb_diff_top import diff_pkg::*; ();

  `include "tb_diff_cases.svh"

  localparam logic [31:0] SEED = 32'h6840_2701;

  // One expected output beat and the cycle it is due in
  typedef struct packed {
    sample_t [NUM_LANES-1:0] y;
    logic                    last;
    logic                    ovf;
    int                      due;
  } exp_beat_t;

  logic    clk;
  logic    rst_n;
  logic    i_valid;
  logic    i_last;
  logic    i_switch;
  sample_t i_data [NUM_LANES];
  sample_t o_y [NUM_LANES];
  logic    o_valid;
  logic    o_last;
  logic    o_frame_ovf;

  int        cyc = 0;
  int        frames_done = 0;
  int        beats_seen = 0;
  int        frame_err = 0;
  int        pass_cnt = 0;
  int        fail_cnt = 0;
  sample_t   frame_x [MAX_SAMPLES];
  exp_beat_t frame_exp [MAX_BEATS];
  exp_beat_t exp_q [$];
  exp_beat_t mon_beat;

  diff_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_valid     (i_valid),
    .i_last      (i_last),
    .i_switch    (i_switch),
    .i_data      (i_data),
    .o_y         (o_y),
    .o_valid     (o_valid),
    .o_last      (o_last),
    .o_frame_ovf (o_frame_ovf)
  );

  always #20 clk = ~clk;

  // Count of rising edges seen so far
  always @(posedge clk) cyc <= cyc + 1;

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_y(input int lane, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      $display("Error: o_y[%0d] = 0x%04h, expected 0x%04h (frame %0d, beat %0d)",
               lane, got, exp, frames_done, beats_seen);
      frame_err++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s = 0x%0h, expected 0x%0h (frame %0d, cycle %0d)",
               name, got, exp, frames_done, cyc);
      frame_err++;
    end
  endtask

  task automatic check_count(input int got, input int exp);
    if (got != exp) begin
      $display("Error: o_valid beats = 0x%0h, expected 0x%0h (frame %0d)",
               got, exp, frames_done);
      frame_err++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic sample_t fill_sample(input frame_case_t fc, input int n);
    sample_t v;
    case (fc.fill)
      FILL_RAND: v = sample_t'($urandom());
      FILL_RAMP: v = sample_t'(n * fc.param);
      default:   v = ((n / fc.param) % 2 == 0) ? FULL_POS : FULL_NEG;
    endcase
    return v;
  endfunction

  // Forward difference at stride s, backward for the last s samples
  task automatic build_frame(input frame_case_t fc);
    int      n_smp;
    int      s;
    int      d_int;
    diff_t   d;
    sample_t packed_y;
    logic    ovf_any;
    n_smp   = fc.beats * NUM_LANES;
    s       = fc.real_mode ? 1 : 2;
    ovf_any = 1'b0;
    for (int n = 0; n < n_smp; n++) begin
      frame_x[n] = fill_sample(fc, n);
    end
    for (int n = 0; n < n_smp; n++) begin
      if (n + s < n_smp) begin
        d_int = int'(frame_x[n + s]) - int'(frame_x[n]);
      end else begin
        d_int = int'(frame_x[n]) - int'(frame_x[n - s]);
      end
      d = diff_t'(d_int);
      // Low 15 bits kept, top bit replaced by the sign of the full result
      packed_y = sample_t'(d_int);
      packed_y[SAMPLE_W-1] = (d < 0);
      frame_exp[n / NUM_LANES].y[n % NUM_LANES] = packed_y;
      // Dropped bit only matters once the result leaves the sample range
      if (d > diff_t'(FULL_POS) || d < diff_t'(FULL_NEG)) begin
        ovf_any = 1'b1;
      end
    end
    for (int k = 0; k < fc.beats; k++) begin
      frame_exp[k].last = (k == fc.beats - 1);
      frame_exp[k].ovf  = ovf_any;
      frame_exp[k].due  = 0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Junk on the data and mode lines while no beat is offered
  task automatic drive_idle();
    i_valid  <= 1'b0;
    i_last   <= 1'b0;
    i_switch <= 1'($urandom());
    for (int i = 0; i < NUM_LANES; i++) begin
      i_data[i] <= sample_t'($urandom());
    end
  endtask

  task automatic drive_frame(input int f);
    frame_case_t fc;
    int          edge_id;
    exp_beat_t   eb;
    fc = CASES[f];
    build_frame(fc);
    for (int k = 0; k < fc.beats; k++) begin
      @(posedge clk);
      i_valid  <= 1'b1;
      i_last   <= (k == fc.beats - 1);
      // Mode flipped after the first beat, it must stay latched
      i_switch <= (k == 0) ? fc.real_mode : !fc.real_mode;
      for (int i = 0; i < NUM_LANES; i++) begin
        i_data[i] <= frame_x[k * NUM_LANES + i];
      end
      // Edge that samples this beat, cyc still shows the previous edge
      edge_id = cyc + 2;
      if (k > 0) begin
        eb     = frame_exp[k - 1];
        eb.due = edge_id + 3;
        exp_q.push_back(eb);
      end
      if (k == fc.beats - 1) begin
        eb     = frame_exp[k];
        eb.due = edge_id + 4;
        exp_q.push_back(eb);
      end
      repeat (fc.gap) begin
        @(posedge clk);
        drive_idle();
      end
    end
  endtask

  function automatic int table_slots();
    int total;
    total = 0;
    for (int c = 0; c < NUM_CASES; c++) begin
      total += CASES[c].beats * (1 + CASES[c].gap);
    end
    return total;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Monitor
  //////////////////////////////////////////////////////////////////////

  task automatic close_frame();
    if (frames_done >= NUM_CASES) begin
      $display("An extra o_last came after all %0d frames were done", NUM_CASES);
      frame_err++;
    end else begin
      check_count(beats_seen, CASES[frames_done].beats);
      $display("frame %0d: %s, %0d beats, gap %0d: %s", frames_done,
               CASES[frames_done].real_mode ? "real" : "complex",
               CASES[frames_done].beats, CASES[frames_done].gap,
               (frame_err == 0) ? "ok" : "mismatch");
      if (frame_err == 0) begin
        pass_cnt++;
      end else begin
        fail_cnt++;
      end
      frames_done++;
      frame_err = 0;
    end
    beats_seen = 0;
  endtask

  always @(negedge clk) begin
    if (o_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Output beat in cycle %0d has no completed input beat behind it", cyc);
        frame_err++;
      end else begin
        mon_beat = exp_q.pop_front();
        if (cyc != mon_beat.due) begin
          $display("Beat %0d of frame %0d came out in cycle %0d instead of cycle %0d",
                   beats_seen, frames_done, cyc, mon_beat.due);
          frame_err++;
        end
        for (int i = 0; i < NUM_LANES; i++) begin
          check_y(i, o_y[i], mon_beat.y[i]);
        end
        check_flag("o_last", o_last, mon_beat.last);
        check_flag("o_frame_ovf", o_frame_ovf, mon_beat.last && mon_beat.ovf);
      end
      beats_seen++;
      if (o_last === 1'b1) begin
        close_frame();
      end
    end else begin
      check_flag("o_valid", o_valid, 1'b0);
      check_flag("o_last", o_last, 1'b0);
      check_flag("o_frame_ovf", o_frame_ovf, 1'b0);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    clk      = 1'b0;
    rst_n    = 1'b0;
    i_valid  = 1'b0;
    i_last   = 1'b0;
    i_switch = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      i_data[i] = '0;
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int f = 0; f < NUM_CASES; f++) begin
      drive_frame(f);
    end
    @(posedge clk);
    drive_idle();
    wait (frames_done == NUM_CASES);
    // Any stray beat after the table would show up here
    repeat (8) @(posedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d expected output beats never came out", exp_q.size());
      frame_err++;
    end
    $display("%0d frames passed, %0d failed, %0d errors outside frames",
             pass_cnt, fail_cnt, frame_err);
    if (fail_cnt == 0 && frame_err == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    limit = table_slots() * 40 * 4 + 2000;
    #(limit);
    $display("Timeout after %0d ns with %0d of %0d frames done",
             limit, frames_done, NUM_CASES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+test
hw/diff_pkg.sv
hw/diff_feeder.sv
hw/diff_lane.sv
hw/diff_collector.sv
hw/diff_top.sv
test/tb_diff_top.sv
